/* rtl/rv_exec_pkg.sv */
`default_nettype none

package rv_exec_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs = 32;

  // issue edge to retire valid
  localparam int retire_latency = 3;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // major opcodes, RV32I encoding
  typedef enum logic [6:0] {
    op_reg = 7'b0110011,
    op_imm = 7'b0010011,
    op_lui = 7'b0110111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_and    = 4'd2,
    alu_or     = 4'd3,
    alu_xor    = 4'd4,
    alu_slt    = 4'd5,
    alu_sltu   = 4'd6,
    alu_sll    = 4'd7,
    alu_srl    = 4'd8,
    alu_sra    = 4'd9,
    alu_pass_b = 4'd10
  } alu_op_e;

  typedef struct packed {
    logic      valid;
    logic      illegal;
    alu_op_e   alu_op;
    logic      use_imm;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    // legal and rd nonzero
    logic      reg_write;
  } decoded_t;

  typedef struct packed {
    decoded_t dec;
    word_t    rs1_data;
    word_t    rs2_data;
  } ex_stage_t;

  // writeback stage, also the retire port
  typedef struct packed {
    logic      valid;
    logic      illegal;
    logic      reg_write;
    reg_addr_t rd;
    word_t     data;
  } retire_t;

endpackage

`default_nettype wire

/* rtl/rv_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decoder (
  input  rv_exec_pkg::word_t    inst,
  input  logic                  valid,
  output rv_exec_pkg::decoded_t decoded
);
  import rv_exec_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_base;
  logic       f7_alt;
  logic       illegal;
  alu_op_e    alu_op;

  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign f7_base = (funct7 == 7'b0000000);
  assign f7_alt = (funct7 == 7'b0100000);

  always_comb begin
    illegal = 1'b0;
    alu_op = alu_add;
    case (opcode)
      op_reg: begin
        case (funct3)
          3'b000: begin
            alu_op = f7_alt ? alu_sub : alu_add;
            illegal = !(f7_base || f7_alt);
          end
          3'b001: alu_op = alu_sll;
          3'b010: alu_op = alu_slt;
          3'b011: alu_op = alu_sltu;
          3'b100: alu_op = alu_xor;
          3'b101: begin
            alu_op = f7_alt ? alu_sra : alu_srl;
            illegal = !(f7_base || f7_alt);
          end
          3'b110: alu_op = alu_or;
          default: alu_op = alu_and;
        endcase
        // only add/sub and srl/sra have an alternate funct7
        if (funct3 != 3'b000 && funct3 != 3'b101) begin
          illegal = !f7_base;
        end
      end
      op_imm: begin
        case (funct3)
          3'b000: alu_op = alu_add;
          3'b001: begin
            alu_op = alu_sll;
            illegal = !f7_base;
          end
          3'b010: alu_op = alu_slt;
          3'b011: alu_op = alu_sltu;
          3'b100: alu_op = alu_xor;
          3'b101: begin
            alu_op = f7_alt ? alu_sra : alu_srl;
            illegal = !(f7_base || f7_alt);
          end
          3'b110: alu_op = alu_or;
          default: alu_op = alu_and;
        endcase
      end
      op_lui: alu_op = alu_pass_b;
      default: illegal = 1'b1;
    endcase
  end

  always_comb begin
    decoded = '0;
    decoded.valid = valid;
    decoded.illegal = illegal;
    decoded.rd = inst[11:7];
    decoded.reg_write = !illegal && (inst[11:7] != '0);
    if (!illegal) begin
      decoded.alu_op = alu_op;
      decoded.use_imm = (opcode != op_reg);
      // lui has no sources, immediate forms no rs2
      decoded.rs1 = (opcode == op_lui) ? '0 : inst[19:15];
      decoded.rs2 = (opcode == op_reg) ? inst[24:20] : '0;
      if (opcode == op_lui) begin
        decoded.imm = {inst[31:12], 12'b0};
      end else begin
        decoded.imm = {{20{inst[31]}}, inst[31:20]};
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_register_file.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_register_file (
  input  logic                   clock,
  input  logic                   reset,
  input  rv_exec_pkg::reg_addr_t rs1,
  input  rv_exec_pkg::reg_addr_t rs2,
  output rv_exec_pkg::word_t     rs1_data,
  output rv_exec_pkg::word_t     rs2_data,
  input  rv_exec_pkg::retire_t   writeback
);
  import rv_exec_pkg::*;

  word_t regs [num_regs];
  logic  write_en;

  assign write_en = writeback.valid && writeback.reg_write && (writeback.rd != '0);

  // x0 reads zero, a same-cycle write is passed through
  function automatic word_t read_port(reg_addr_t addr, word_t stored, logic wen,
                                      retire_t wb);
    word_t value;
    if (addr == '0) begin
      value = '0;
    end else if (wen && (wb.rd == addr)) begin
      value = wb.data;
    end else begin
      value = stored;
    end
    return value;
  endfunction

  assign rs1_data = read_port(rs1, regs[rs1], write_en, writeback);
  assign rs2_data = read_port(rs2, regs[rs2], write_en, writeback);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[writeback.rd] <= writeback.data;
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_bypass.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_bypass (
  input  rv_exec_pkg::ex_stage_t ex,
  input  rv_exec_pkg::retire_t   writeback,
  output rv_exec_pkg::word_t     operand_a,
  output rv_exec_pkg::word_t     operand_b
);
  import rv_exec_pkg::*;

  word_t src_b;

  // older result still in writeback wins over the value read in decode
  function automatic word_t forward(reg_addr_t src, word_t read_value, retire_t wb);
    word_t value;
    if (wb.valid && wb.reg_write && (wb.rd == src)) begin
      value = wb.data;
    end else begin
      value = read_value;
    end
    return value;
  endfunction

  assign operand_a = forward(ex.dec.rs1, ex.rs1_data, writeback);
  assign src_b = forward(ex.dec.rs2, ex.rs2_data, writeback);

  assign operand_b = ex.dec.use_imm ? ex.dec.imm : src_b;

endmodule

`default_nettype wire

/* rtl/rv_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_alu (
  input  rv_exec_pkg::alu_op_e alu_op,
  input  rv_exec_pkg::word_t   operand_a,
  input  rv_exec_pkg::word_t   operand_b,
  output rv_exec_pkg::word_t   result
);
  import rv_exec_pkg::*;

  logic [4:0] shamt;
  logic       less_signed;
  logic       less_unsigned;

  assign shamt = operand_b[4:0];
  assign less_signed = $signed(operand_a) < $signed(operand_b);
  assign less_unsigned = operand_a < operand_b;

  always_comb begin
    case (alu_op)
      alu_add: begin
        result = operand_a + operand_b;
      end
      alu_sub: begin
        result = operand_a - operand_b;
      end
      alu_and: begin
        result = operand_a & operand_b;
      end
      alu_or: begin
        result = operand_a | operand_b;
      end
      alu_xor: begin
        result = operand_a ^ operand_b;
      end
      alu_slt: begin
        result = {{(xlen-1){1'b0}}, less_signed};
      end
      alu_sltu: begin
        result = {{(xlen-1){1'b0}}, less_unsigned};
      end
      alu_sll: begin
        result = operand_a << shamt;
      end
      alu_srl: begin
        result = operand_a >> shamt;
      end
      alu_sra: begin
        // arithmetic shift keeps the sign
        result = word_t'($signed(operand_a) >>> shamt);
      end
      alu_pass_b: begin
        result = operand_b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/rv_exec_pipeline.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_exec_pipeline (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 inst_valid,
  input  rv_exec_pkg::word_t   inst,
  output rv_exec_pkg::retire_t retire
);
  import rv_exec_pkg::*;

  // issue stage
  logic      issue_valid;
  word_t     issue_inst;
  decoded_t  id_decoded;
  word_t     id_rs1_data;
  word_t     id_rs2_data;

  // execute stage
  ex_stage_t ex_d;
  ex_stage_t ex_q;
  word_t     operand_a;
  word_t     operand_b;
  word_t     alu_result;

  // writeback stage
  retire_t   wb_d;
  retire_t   wb_q;

  rv_decoder decoder (
    .inst    (issue_inst),
    .valid   (issue_valid),
    .decoded (id_decoded)
  );

  rv_register_file register_file (
    .clock     (clock),
    .reset     (reset),
    .rs1       (id_decoded.rs1),
    .rs2       (id_decoded.rs2),
    .rs1_data  (id_rs1_data),
    .rs2_data  (id_rs2_data),
    .writeback (wb_q)
  );

  always_comb begin
    ex_d.dec = id_decoded;
    ex_d.rs1_data = id_rs1_data;
    ex_d.rs2_data = id_rs2_data;
  end

  rv_bypass bypass (
    .ex        (ex_q),
    .writeback (wb_q),
    .operand_a (operand_a),
    .operand_b (operand_b)
  );

  rv_alu alu (
    .alu_op    (ex_q.dec.alu_op),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .result    (alu_result)
  );

  always_comb begin
    wb_d.valid = ex_q.dec.valid;
    wb_d.illegal = ex_q.dec.illegal;
    wb_d.reg_write = ex_q.dec.reg_write;
    wb_d.rd = ex_q.dec.rd;
    // illegal instructions retire with zero data
    wb_d.data = ex_q.dec.illegal ? '0 : alu_result;
  end

  // payload moves every edge, only the valid bits see reset
  always_ff @(posedge clock) begin
    issue_inst <= inst;
    ex_q <= ex_d;
    wb_q <= wb_d;
    if (reset) begin
      issue_valid <= 1'b0;
      ex_q.dec.valid <= 1'b0;
      wb_q.valid <= 1'b0;
    end else begin
      issue_valid <= inst_valid;
    end
  end

  assign retire = wb_q;

endmodule

`default_nettype wire

/* verification/rv_retire_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_retire_checker (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 expect_valid,
  input  rv_exec_pkg::retire_t expect_entry,
  input  rv_exec_pkg::retire_t retire,
  output int                   value_errors,
  output int                   order_errors,
  output int                   pending
);
  import rv_exec_pkg::*;

  retire_t expected_q[$];
  int      issue_edge_q[$];
  int      edge_count;
  retire_t head;
  int      head_edge;

  // sampled on the same edge the DUT captures its inputs
  always @(posedge clock) begin
    if (reset) begin
      expected_q.delete();
      issue_edge_q.delete();
      edge_count = 0;
      value_errors = 0;
      order_errors = 0;
    end else begin
      edge_count = edge_count + 1;
      if (expect_valid) begin
        expected_q.push_back(expect_entry);
        issue_edge_q.push_back(edge_count);
      end
      if (retire.valid) begin
        if (expected_q.size() == 0) begin
          $display("unexpected retire at time %0t with no instruction waiting to retire",
                   $time);
          order_errors = order_errors + 1;
        end else begin
          head = expected_q.pop_front();
          head_edge = issue_edge_q.pop_front();
          if (edge_count - head_edge != retire_latency) begin
            $display("retire at time %0t came %0d edges after issue instead of %0d",
                     $time, edge_count - head_edge, retire_latency);
            order_errors = order_errors + 1;
          end
          if (retire.illegal !== head.illegal) begin
            $display("[ERROR] %0t: illegal %0b, expected %0b", $time, retire.illegal,
                     head.illegal);
            value_errors = value_errors + 1;
          end
          if (retire.reg_write !== head.reg_write) begin
            $display("[ERROR] %0t: reg_write %0b, expected %0b", $time, retire.reg_write,
                     head.reg_write);
            value_errors = value_errors + 1;
          end
          if (retire.rd !== head.rd) begin
            $display("[ERROR] %0t: rd %0d, expected %0d", $time, retire.rd, head.rd);
            value_errors = value_errors + 1;
          end
          if (retire.data !== head.data) begin
            $display("[ERROR] %0t: data %h, expected %h", $time, retire.data, head.data);
            value_errors = value_errors + 1;
          end
        end
      end
    end
    pending = expected_q.size();
  end

endmodule

`default_nettype wire

/* verification/tb_rv_exec.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_exec;
  import rv_exec_pkg::*;

  typedef struct packed {
    word_t   inst;
    logic    tight;
    retire_t expected;
  } entry_t;

  logic        clock = 1'b0;
  logic        reset;
  logic        inst_valid;
  word_t       inst;
  retire_t     retire;
  logic        expect_valid;
  retire_t     expect_entry;
  int          value_errors;
  int          order_errors;
  int          pending;
  entry_t      program_q[$];
  int unsigned lcg_state;
  int          gap;
  int          cycle_count = 0;
  int          cycle_limit;

  rv_exec_pipeline uut (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .retire     (retire)
  );

  rv_retire_checker retire_check (
    .clock        (clock),
    .reset        (reset),
    .expect_valid (expect_valid),
    .expect_entry (expect_entry),
    .retire       (retire),
    .value_errors (value_errors),
    .order_errors (order_errors),
    .pending      (pending)
  );

  always #20 clock = ~clock;

  function automatic word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                   logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic word_t u_type(logic [19:0] imm, logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  task automatic add_entry(input word_t word, input logic [4:0] rd, input word_t data,
                           input logic reg_write, input logic illegal, input logic tight);
    entry_t entry;
    entry.inst = word;
    entry.tight = tight;
    entry.expected.valid = 1'b1;
    entry.expected.illegal = illegal;
    entry.expected.reg_write = reg_write;
    entry.expected.rd = rd;
    entry.expected.data = data;
    program_q.push_back(entry);
  endtask

  // word, rd, data, reg_write, illegal, no gap before it
  task automatic load_program();
    add_entry(i_type(12'd5, 0, 3'b000, 1), 1, 32'd5, 1, 0, 0);
    add_entry(i_type(12'hffd, 0, 3'b000, 2), 2, 32'hffff_fffd, 1, 0, 0);
    add_entry(r_type(7'h00, 2, 1, 3'b000, 3), 3, 32'd2, 1, 0, 1);
    add_entry(r_type(7'h20, 2, 1, 3'b000, 4), 4, 32'd8, 1, 0, 1);
    add_entry(r_type(7'h00, 2, 1, 3'b111, 5), 5, 32'd5, 1, 0, 0);
    add_entry(r_type(7'h00, 2, 1, 3'b110, 6), 6, 32'hffff_fffd, 1, 0, 0);
    add_entry(r_type(7'h00, 2, 1, 3'b100, 7), 7, 32'hffff_fff8, 1, 0, 0);
    add_entry(r_type(7'h00, 1, 2, 3'b010, 8), 8, 32'd1, 1, 0, 0);
    add_entry(r_type(7'h00, 1, 2, 3'b011, 9), 9, 32'd0, 1, 0, 0);
    add_entry(r_type(7'h00, 2, 1, 3'b011, 11), 11, 32'd1, 1, 0, 0);
    add_entry(u_type(20'h80000, 12), 12, 32'h8000_0000, 1, 0, 0);
    add_entry(r_type(7'h20, 1, 12, 3'b101, 13), 13, 32'hfc00_0000, 1, 0, 1);
    add_entry(r_type(7'h00, 1, 12, 3'b101, 14), 14, 32'h0400_0000, 1, 0, 1);
    add_entry(r_type(7'h00, 1, 1, 3'b001, 15), 15, 32'h0000_00a0, 1, 0, 0);
    add_entry(i_type(12'h0f0, 7, 3'b111, 16), 16, 32'h0000_00f0, 1, 0, 0);
    add_entry(i_type(12'h700, 1, 3'b110, 17), 17, 32'h0000_0705, 1, 0, 0);
    add_entry(i_type(12'hfff, 1, 3'b100, 18), 18, 32'hffff_fffa, 1, 0, 0);
    add_entry(i_type(12'hffe, 2, 3'b010, 19), 19, 32'd1, 1, 0, 0);
    add_entry(i_type(12'hfff, 1, 3'b011, 20), 20, 32'd1, 1, 0, 0);
    add_entry(i_type(12'h003, 1, 3'b001, 21), 21, 32'h0000_0028, 1, 0, 0);
    add_entry(i_type(12'h004, 12, 3'b101, 22), 22, 32'h0800_0000, 1, 0, 0);
    add_entry(i_type(12'h404, 12, 3'b101, 23), 23, 32'hf800_0000, 1, 0, 0);
    // dependency chain at distances one to three
    add_entry(i_type(12'd100, 0, 3'b000, 24), 24, 32'd100, 1, 0, 0);
    add_entry(i_type(12'd1, 24, 3'b000, 24), 24, 32'd101, 1, 0, 1);
    add_entry(r_type(7'h00, 24, 24, 3'b000, 25), 25, 32'd202, 1, 0, 1);
    add_entry(r_type(7'h00, 25, 24, 3'b000, 26), 26, 32'd303, 1, 0, 1);
    add_entry(r_type(7'h20, 24, 26, 3'b000, 27), 27, 32'd202, 1, 0, 1);
    // x0 as destination
    add_entry(i_type(12'd9, 1, 3'b000, 0), 0, 32'd14, 0, 0, 0);
    add_entry(r_type(7'h00, 1, 0, 3'b000, 31), 31, 32'd5, 1, 0, 1);
    // unsupported encodings
    add_entry(r_type(7'h01, 1, 1, 3'b000, 1), 1, 32'd0, 0, 1, 0);
    add_entry(32'hffff_ffff, 31, 32'd0, 0, 1, 1);
    add_entry(i_type(12'd0, 1, 3'b000, 2), 2, 32'd5, 1, 0, 1);
    add_entry(r_type(7'h00, 0, 31, 3'b000, 3), 3, 32'd5, 1, 0, 1);
    add_entry(i_type(12'h401, 1, 3'b001, 5), 5, 32'd0, 0, 1, 0);
    add_entry(i_type(12'd0, 5, 3'b000, 4), 4, 32'd5, 1, 0, 1);
  endtask

  task automatic print_counts();
    $display("value errors: %0d, order errors: %0d, unretired: %0d", value_errors,
             order_errors, pending);
  endtask

  always @(negedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles with %0d expected results never retired",
               cycle_count, pending);
      print_counts();
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    reset = 1'b1;
    inst_valid = 1'b0;
    inst = '0;
    expect_valid = 1'b0;
    expect_entry = '0;
    lcg_state = 44;
    load_program();
    cycle_limit = program_q.size() * 4 + 20;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    // idle after reset, nothing may retire
    repeat (3) @(posedge clock);
    for (int i = 0; i < program_q.size(); i++) begin
      if (!program_q[i].tight) begin
        gap = next_random() % 3;
        repeat (gap) begin
          @(posedge clock);
          inst_valid <= 1'b0;
          expect_valid <= 1'b0;
        end
      end
      @(posedge clock);
      inst_valid <= 1'b1;
      inst <= program_q[i].inst;
      expect_valid <= 1'b1;
      expect_entry <= program_q[i].expected;
    end
    @(posedge clock);
    inst_valid <= 1'b0;
    expect_valid <= 1'b0;
    @(negedge clock);
    while (pending != 0) begin
      @(negedge clock);
    end
    // a few more cycles to catch stray retires
    repeat (4) @(negedge clock);
    print_counts();
    if (value_errors + order_errors + pending == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
rtl/rv_exec_pkg.sv
rtl/rv_decoder.sv
rtl/rv_register_file.sv
rtl/rv_bypass.sv
rtl/rv_alu.sv
rtl/rv_exec_pipeline.sv
verification/rv_retire_checker.sv
verification/tb_rv_exec.sv
